//--- design/board_status_pkg.sv
`default_nettype none

package board_status_pkg;

    // display and timing
    localparam int DIGITS        = 8;
    localparam int SCAN_DIV      = 16;
    localparam int LOAD_STEP     = 64;
    localparam int HEARTBEAT_DIV = 256;
    localparam int DISP_SHIFT    = 10;
    localparam int PWM_BITS      = 12;

    localparam int DIGIT_BITS = $clog2(DIGITS);
    localparam int SCAN_BITS  = $clog2(SCAN_DIV);
    localparam int LOAD_BITS  = $clog2(LOAD_STEP);
    localparam int HB_BITS    = $clog2(HEARTBEAT_DIV);

    // core mode field values
    localparam logic [3:0] MODE_RUN  = 4'd0;
    localparam logic [3:0] MODE_BOOT = 4'd1;

    // breathing phase offsets and per-period steps
    localparam logic [PWM_BITS:0] PHASE_INIT_B = 13'd0;
    localparam logic [PWM_BITS:0] PHASE_INIT_G = 13'd64;
    localparam logic [PWM_BITS:0] PHASE_INIT_R = 13'd512;
    localparam logic [PWM_BITS:0] PHASE_STEP_B = 13'd2;
    localparam logic [PWM_BITS:0] PHASE_STEP_G = 13'd3;
    localparam logic [PWM_BITS:0] PHASE_STEP_R = 13'd5;

    typedef logic [31:0] word_t;
    typedef logic [63:0] cnt64_t;

    // segment bits are {dp, a, b, c, d, e, f, g}, active high
    localparam logic [7:0] HEX_SEG [16] = '{
        8'b01111110, 8'b00110000, 8'b01101101, 8'b01111001,
        8'b00110011, 8'b01011011, 8'b01011111, 8'b01110000,
        8'b01111111, 8'b01111011, 8'b01110111, 8'b00011111,
        8'b01001110, 8'b00111101, 8'b01001111, 8'b01000111
    };

    // reads "ArchProc" from the leftmost digit
    localparam logic [7:0] BANNER_SEG [DIGITS] = '{
        8'b00001101, 8'b00011101, 8'b00000101, 8'b01100111,
        8'b00010111, 8'b00001101, 8'b00000101, 8'b01110111
    };

    // blanks, "Loading", then two dots
    localparam logic [7:0] LOAD_FRAME [16] = '{
        8'b00000000, 8'b00000000, 8'b00000000, 8'b00000000,
        8'b00000000, 8'b00000000, 8'b00000000, 8'b00001110,
        8'b00011101, 8'b01111101, 8'b00111101, 8'b00010000,
        8'b00010101, 8'b11111011, 8'b10000000, 8'b10000000
    };

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic center;
    } buttons_t;

    typedef struct packed {
        cnt64_t mtime;
        cnt64_t mtimecmp;
        word_t  pc;
        word_t  ir;
        word_t  checksum;
    } probe_t;

    typedef struct packed {
        logic       init_done;
        logic       init_start;
        logic       halt;
        logic       finish;
        logic       busy;
        logic       data_we;
        priv_e      priv;
        logic [3:0] mode;
    } core_status_t;

    // both bytes active low
    typedef struct packed {
        logic [7:0]        sg;
        logic [DIGITS-1:0] an;
    } seg_drive_t;

    typedef struct packed {
        logic blue;
        logic green;
        logic red;
    } rgb_t;

endpackage

`default_nettype wire

//--- design/run_status_regs.sv
`timescale 1ns/1ps
`default_nettype none

module run_status_regs (
    input  logic                          CORE_CLK,
    input  logic                          rst,
    input  board_status_pkg::core_status_t core,
    input  board_status_pkg::probe_t      probe,
    input  board_status_pkg::buttons_t    buttons,
    output logic                          loading,
    output logic                          running,
    output board_status_pkg::word_t       disp_word,
    output logic                          core_stall
);
    import board_status_pkg::*;

    cnt64_t run_cnt;
    word_t  view_word;

    // sticky stop cleared only by reset
    always_ff @(posedge CORE_CLK) begin
        if (rst) begin
            core_stall <= 1'b0;
        end else if (core.halt || core.finish || buttons.center) begin
            core_stall <= 1'b1;
        end
    end

    // counts cycles the core actually runs
    always_ff @(posedge CORE_CLK) begin
        if (rst) begin
            run_cnt <= '0;
        end else if (core.init_done && !core_stall && core.mode == MODE_RUN) begin
            run_cnt <= run_cnt + 64'd1;
        end
    end

    always_ff @(posedge CORE_CLK) begin
        if (rst) begin
            loading <= 1'b0;
            running <= 1'b0;
        end else begin
            running <= core.init_done;
            if (core.init_start && !core.init_done) begin
                loading <= 1'b1;
            end else if (core.init_done) begin
                loading <= 1'b0;
            end
        end
    end

    // button view select in priority order
    always_comb begin
        if (buttons.up) begin
            view_word = run_cnt[DISP_SHIFT +: 32];
        end else if (buttons.down) begin
            view_word = probe.checksum;
        end else if (buttons.center) begin
            view_word = probe.mtimecmp[31:0];
        end else if (buttons.left) begin
            view_word = probe.pc;
        end else if (buttons.right) begin
            view_word = probe.ir;
        end else begin
            view_word = probe.mtime[DISP_SHIFT +: 32];
        end
    end

    always_ff @(posedge CORE_CLK) begin
        if (rst) begin
            disp_word <= '0;
        end else begin
            disp_word <= view_word;
        end
    end

endmodule

`default_nettype wire

//--- design/seg_scan_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module seg_scan_ctrl (
    input  logic                         CORE_CLK,
    input  logic                         rst,
    input  logic                         loading,
    input  logic                         running,
    input  board_status_pkg::word_t      disp_word,
    output board_status_pkg::seg_drive_t seg
);
    import board_status_pkg::*;

    logic [SCAN_BITS-1:0]  scan_cnt;
    logic                  scan_tick;
    logic [DIGIT_BITS-1:0] digit;
    logic [DIGIT_BITS-1:0] lit_digit;
    logic [3:0]            nibble;
    logic [LOAD_BITS-1:0]  load_cnt;
    logic [3:0]            load_step;
    logic [3:0]            frame_idx;
    logic [7:0]            pattern;

    assign scan_tick = (scan_cnt == '0);

    // scan divider
    always_ff @(posedge CORE_CLK) begin
        if (rst) begin
            scan_cnt <= '0;
        end else if (scan_cnt == SCAN_BITS'(SCAN_DIV - 1)) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // digit counter and anode drive
    always_ff @(posedge CORE_CLK) begin
        if (rst) begin
            digit     <= '0;
            lit_digit <= '0;
            seg.an    <= '1;
        end else if (scan_tick) begin
            if (digit == DIGIT_BITS'(DIGITS - 1)) begin
                digit <= '0;
            end else begin
                digit <= digit + 1'b1;
            end
            lit_digit <= digit;
            seg.an    <= ~(DIGITS'(1) << digit);
        end
    end

    // nibble shown with the new anode
    always_ff @(posedge CORE_CLK) begin
        if (rst) begin
            nibble <= '0;
        end else if (scan_tick) begin
            nibble <= disp_word[{digit, 2'b00} +: 4];
        end
    end

    // loading scroll steps once per LOAD_STEP loading cycles
    always_ff @(posedge CORE_CLK) begin
        if (rst) begin
            load_cnt  <= '0;
            load_step <= '0;
        end else if (loading) begin
            if (load_cnt == LOAD_BITS'(LOAD_STEP - 1)) begin
                load_cnt <= '0;
            end else begin
                load_cnt <= load_cnt + 1'b1;
            end
            if (load_cnt == '0) begin
                load_step <= load_step + 4'd1;
            end
        end
    end

    // leftmost digit shows the lowest strip entry
    assign frame_idx = load_step + 4'd7 - 4'(lit_digit);

    always_comb begin
        if (loading) begin
            pattern = LOAD_FRAME[frame_idx];
        end else if (running) begin
            pattern = HEX_SEG[nibble];
        end else begin
            pattern = BANNER_SEG[lit_digit];
        end
    end

    // segments lag the anode by one cycle
    always_ff @(posedge CORE_CLK) begin
        if (rst) begin
            seg.sg <= '1;
        end else begin
            seg.sg <= ~pattern;
        end
    end

endmodule

`default_nettype wire

//--- design/board_led_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module board_led_ctrl (
    input  logic                          CORE_CLK,
    input  logic                          rst,
    input  board_status_pkg::core_status_t core,
    input  logic                          led_off,
    output logic [15:0]                   led,
    output board_status_pkg::rgb_t        rgb
);
    import board_status_pkg::*;

    logic [HB_BITS-1:0]  hb_cnt;
    logic [PWM_BITS-1:0] pwm_cnt;
    logic [PWM_BITS:0]   phase_b;
    logic [PWM_BITS:0]   phase_g;
    logic [PWM_BITS:0]   phase_r;
    logic [3:0]          blink_cnt;
    rgb_t                breathe;
    rgb_t                rgb_next;

    // top phase bit flips the duty direction so the LED fades both ways
    function automatic logic pwm_bit(input logic [PWM_BITS:0] phase,
                                     input logic [PWM_BITS-1:0] ramp);
        if (phase[PWM_BITS]) begin
            return phase[PWM_BITS-1:0] < ramp;
        end
        return phase[PWM_BITS-1:0] >= ramp;
    endfunction

    // heartbeat and status LEDs
    always_ff @(posedge CORE_CLK) begin
        if (rst) begin
            hb_cnt <= '0;
            led    <= '0;
        end else begin
            if (hb_cnt == HB_BITS'(HEARTBEAT_DIV - 1)) begin
                hb_cnt <= '0;
                led[0] <= ~led[0];
            end else begin
                hb_cnt <= hb_cnt + 1'b1;
            end
            led[3:1]  <= {core.busy, core.data_we, core.init_done};
            led[15:4] <= '0;
        end
    end

    // PWM ramp and the three breathing phases
    always_ff @(posedge CORE_CLK) begin
        if (rst) begin
            pwm_cnt   <= '0;
            blink_cnt <= '0;
            phase_b   <= PHASE_INIT_B;
            phase_g   <= PHASE_INIT_G;
            phase_r   <= PHASE_INIT_R;
        end else begin
            pwm_cnt   <= pwm_cnt + 1'b1;
            blink_cnt <= blink_cnt + 4'd1;
            if (pwm_cnt == '0) begin
                phase_b <= phase_b + PHASE_STEP_B;
                phase_g <= phase_g + PHASE_STEP_G;
                phase_r <= phase_r + PHASE_STEP_R;
            end
        end
    end

    assign breathe.blue  = pwm_bit(phase_b, pwm_cnt);
    assign breathe.green = pwm_bit(phase_g, pwm_cnt);
    assign breathe.red   = pwm_bit(phase_r, pwm_cnt);

    always_comb begin
        rgb_next = '0;
        if (led_off) begin
            rgb_next = '0;
        end else if (core.mode == MODE_BOOT) begin
            rgb_next = breathe;
        end else if (core.init_done && blink_cnt == 4'd0) begin
            // short flash in the privilege colour
            case (core.priv)
                PRIV_U:  rgb_next.blue  = 1'b1;
                PRIV_S:  rgb_next.green = 1'b1;
                PRIV_M:  rgb_next.red   = 1'b1;
                default: rgb_next = '0;
            endcase
        end
    end

    always_ff @(posedge CORE_CLK) begin
        if (rst) begin
            rgb <= '0;
        end else begin
            rgb <= rgb_next;
        end
    end

endmodule

`default_nettype wire

//--- design/board_status_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_status_top (
    input  logic                          CORE_CLK,
    input  logic                          rst,
    input  board_status_pkg::core_status_t core,
    input  board_status_pkg::probe_t      probe,
    input  board_status_pkg::buttons_t    buttons,
    input  logic                          led_off,
    output board_status_pkg::seg_drive_t  seg,
    output logic [15:0]                   led,
    output board_status_pkg::rgb_t        rgb,
    output logic                          core_stall
);
    import board_status_pkg::*;

    logic  loading;
    logic  running;
    word_t disp_word;

    // run state and selected probe word
    run_status_regs u_regs (
        .CORE_CLK   (CORE_CLK),
        .rst        (rst),
        .core       (core),
        .probe      (probe),
        .buttons    (buttons),
        .loading    (loading),
        .running    (running),
        .disp_word  (disp_word),
        .core_stall (core_stall)
    );

    seg_scan_ctrl u_scan (
        .CORE_CLK  (CORE_CLK),
        .rst       (rst),
        .loading   (loading),
        .running   (running),
        .disp_word (disp_word),
        .seg       (seg)
    );

    board_led_ctrl u_led (
        .CORE_CLK (CORE_CLK),
        .rst      (rst),
        .core     (core),
        .led_off  (led_off),
        .led      (led),
        .rgb      (rgb)
    );

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic CORE_CLK,
    output logic rst
);

    // 4 ns period
    initial begin
        CORE_CLK = 1'b0;
        forever begin
            #2 CORE_CLK = ~CORE_CLK;
        end
    end

    // reset held for four rising edges, released just after the last one
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge CORE_CLK);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- tb/board_status_tb.sv
`timescale 1ns/1ps
`default_nettype none

module board_status_tb;
    import board_status_pkg::*;

    logic         CORE_CLK;
    logic         rst;
    core_status_t core;
    probe_t       probe;
    buttons_t     buttons;
    logic         led_off;
    seg_drive_t   seg;
    logic [15:0]  led;
    rgb_t         rgb;
    logic         core_stall;

    int unsigned errors = 0;
    int unsigned timeouts = 0;
    logic [31:0] lfsr = 32'h53f9;

    // reference model state
    int unsigned cyc;
    int unsigned m_lcnt;
    int unsigned settled;
    logic        m_loading;
    logic        m_running;
    logic        m_stall;
    cnt64_t      m_run_cnt;
    logic [3:0]  m_step;
    word_t       m_word;
    logic        view_ok;
    logic [$bits(probe_t)+6:0] in_vec;
    logic [$bits(probe_t)+6:0] last_in;

    tb_clk_gen u_clk (
        .CORE_CLK (CORE_CLK),
        .rst      (rst)
    );

    board_status_top u_dut (
        .CORE_CLK   (CORE_CLK),
        .rst        (rst),
        .core       (core),
        .probe      (probe),
        .buttons    (buttons),
        .led_off    (led_off),
        .seg        (seg),
        .led        (led),
        .rgb        (rgb),
        .core_stall (core_stall)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
    endfunction

    function automatic word_t select_word(input buttons_t b, input probe_t p, input cnt64_t c);
        if (b.up) return c[DISP_SHIFT +: 32];
        if (b.down) return p.checksum;
        if (b.center) return p.mtimecmp[31:0];
        if (b.left) return p.pc;
        if (b.right) return p.ir;
        return p.mtime[DISP_SHIFT +: 32];
    endfunction

    // anode expected after n cycles out of reset
    function automatic logic [7:0] exp_anode(input int unsigned n);
        return ~(8'd1 << (((n - 1) / SCAN_DIV) % DIGITS));
    endfunction

    function automatic logic [7:0] exp_seg(input logic [7:0] an, input logic ld,
                                           input logic rn, input logic [3:0] step,
                                           input word_t w);
        int d;
        int i;
        d = 0;
        for (i = 0; i < DIGITS; i++) begin
            if (!an[i]) d = i;
        end
        if (ld) return ~LOAD_FRAME[(int'(step) + 7 - d) % 16];
        if (rn) return ~HEX_SEG[w[4*d +: 4]];
        return ~BANNER_SEG[d];
    endfunction

    function automatic rgb_t priv_colour(input logic [1:0] p);
        rgb_t c;
        c = '0;
        case (p)
            2'd0: c.blue = 1'b1;
            2'd1: c.green = 1'b1;
            2'd3: c.red = 1'b1;
            default: c = '0;
        endcase
        return c;
    endfunction

    // one scroll step on the first loading cycle and every LOAD_STEP after
    assign m_step  = 4'(((m_lcnt + LOAD_STEP - 1) / LOAD_STEP) % 16);
    assign m_word  = select_word(buttons, probe, m_run_cnt);
    assign in_vec  = {probe, buttons, core.init_done, m_stall};
    assign view_ok = settled >= 48 && (!buttons.up || m_stall);

    always @(posedge CORE_CLK) begin
        if (rst) begin
            cyc       <= 0;
            m_lcnt    <= 0;
            settled   <= 0;
            m_loading <= 1'b0;
            m_running <= 1'b0;
            m_stall   <= 1'b0;
            m_run_cnt <= '0;
            last_in   <= '0;
        end else begin
            cyc       <= cyc + 1;
            m_running <= core.init_done;
            if (core.init_start && !core.init_done) m_loading <= 1'b1;
            else if (core.init_done) m_loading <= 1'b0;
            if (m_loading) m_lcnt <= m_lcnt + 1;
            if (core.halt || core.finish || buttons.center) m_stall <= 1'b1;
            if (core.init_done && !m_stall && core.mode == 4'd0) m_run_cnt <= m_run_cnt + 1;
            last_in <= in_vec;
            if (in_vec != last_in) settled <= 0;
            else if (settled < 1000) settled <= settled + 1;
        end
    end

    a_reset: assert property (@(posedge CORE_CLK) $past(rst) |->
        seg == '1 && led == '0 && rgb == '0 && !core_stall)
        else begin
            errors++;
            $display("mismatch at %0t: outputs not idle after reset", $time);
        end

    a_anode: assert property (@(posedge CORE_CLK) disable iff (rst)
        cyc >= 1 |-> seg.an == exp_anode(cyc))
        else begin
            errors++;
            $display("mismatch at %0t: anode byte %h", $time, $sampled(seg.an));
        end

    a_segment: assert property (@(posedge CORE_CLK) disable iff (rst)
        cyc >= 2 && (!$past(m_running) || $past(m_loading) || view_ok) |->
        seg.sg == exp_seg($past(seg.an), $past(m_loading), $past(m_running),
                          $past(m_step), $past(m_word)))
        else begin
            errors++;
            $display("mismatch at %0t: segment byte %h", $time, $sampled(seg.sg));
        end

    // stopped counter view holds still over a whole scan
    a_frozen: assert property (@(posedge CORE_CLK) disable iff (rst)
        buttons.up && m_stall && settled >= 200 |->
        seg.sg == $past(seg.sg, SCAN_DIV * DIGITS))
        else begin
            errors++;
            $display("mismatch at %0t: stopped view changed", $time);
        end

    a_stall: assert property (@(posedge CORE_CLK) disable iff (rst) core_stall == m_stall)
        else begin
            errors++;
            $display("mismatch at %0t: core_stall %b", $time, $sampled(core_stall));
        end

    a_heartbeat: assert property (@(posedge CORE_CLK) disable iff (rst)
        led[0] == 1'((cyc / HEARTBEAT_DIV) % 2))
        else begin
            errors++;
            $display("mismatch at %0t: heartbeat led %b", $time, $sampled(led[0]));
        end

    a_status_led: assert property (@(posedge CORE_CLK) disable iff (rst)
        cyc >= 2 |-> led[3:1] == $past({core.busy, core.data_we, core.init_done})
        && led[15:4] == '0)
        else begin
            errors++;
            $display("mismatch at %0t: status leds %h", $time, $sampled(led));
        end

    a_led_off: assert property (@(posedge CORE_CLK) disable iff (rst)
        cyc >= 2 && $past(led_off) |-> rgb == '0)
        else begin
            errors++;
            $display("mismatch at %0t: rgb %b lit while disabled", $time, $sampled(rgb));
        end

    a_priv_rgb: assert property (@(posedge CORE_CLK) disable iff (rst)
        cyc >= 2 && !$past(led_off) && $past(core.mode) != MODE_BOOT |->
        rgb == '0 || ($past(core.init_done) && rgb == priv_colour($past(core.priv))))
        else begin
            errors++;
            $display("mismatch at %0t: rgb %b not the privilege colour", $time,
                     $sampled(rgb));
        end

    task automatic step();
        @(posedge CORE_CLK);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    task automatic rand_word(output word_t w);
        int i;
        for (i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w[i] = lfsr[0];
        end
    endtask

    task automatic fill_probe();
        rand_word(probe.mtime[63:32]);
        rand_word(probe.mtime[31:0]);
        rand_word(probe.mtimecmp[63:32]);
        rand_word(probe.mtimecmp[31:0]);
        rand_word(probe.pc);
        rand_word(probe.ir);
        rand_word(probe.checksum);
    endtask

    // reset is sampled on the edge, away from its own update time
    task automatic wait_reset_release(input int limit);
        int n;
        n = 0;
        @(posedge CORE_CLK);
        while (rst && n < limit) begin
            @(posedge CORE_CLK);
            n++;
        end
        #1;
        if (rst) begin
            timeouts++;
            $display("reset was never released");
        end
    endtask

    task automatic wait_stall(input int limit);
        int n;
        n = 0;
        while (!core_stall && n < limit) begin
            step();
            n++;
        end
        if (!core_stall) begin
            timeouts++;
            $display("core_stall did not rise after a stop request");
        end
    endtask

    task automatic wait_rgb_lit(input int limit);
        int n;
        n = 0;
        while (rgb == '0 && n < limit) begin
            step();
            n++;
        end
        if (rgb == '0) begin
            timeouts++;
            $display("rgb never flashed for priv %0d", core.priv);
        end
    endtask

    initial begin
        core    = '0;
        probe   = '0;
        buttons = '0;
        led_off = 1'b0;
        wait_reset_release(20);
        idle(300);
        // boot with breathing LED and the loading scroll
        core.mode       = MODE_BOOT;
        core.init_start = 1'b1;
        step();
        core.init_start = 1'b0;
        idle(1200);
        fill_probe();
        core.mode      = MODE_RUN;
        core.init_done = 1'b1;
        repeat (64) begin
            lfsr = lfsr_step(lfsr);
            core.busy = lfsr[0];
            lfsr = lfsr_step(lfsr);
            core.data_we = lfsr[0];
            step();
        end
        idle(200);
        buttons.up = 1'b1;
        idle(100);
        buttons = '0;
        buttons.down = 1'b1;
        idle(200);
        buttons = '0;
        buttons.left = 1'b1;
        idle(200);
        buttons = '0;
        buttons.right = 1'b1;
        idle(200);
        buttons = '0;
        idle(200);
        for (int p = 0; p < 4; p++) begin
            core.priv = priv_e'(p);
            if (p != 2) wait_rgb_lit(40);
            idle(40);
        end
        led_off = 1'b1;
        idle(64);
        led_off = 1'b0;
        buttons.center = 1'b1;
        wait_stall(8);
        idle(200);
        buttons = '0;
        buttons.up = 1'b1;
        core.halt = 1'b1;
        step();
        core.halt = 1'b0;
        idle(400);
        $display("errors %0d timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- board_status_top.f
design/board_status_pkg.sv
design/run_status_regs.sv
design/seg_scan_ctrl.sv
design/board_led_ctrl.sv
design/board_status_top.sv
tb/tb_clk_gen.sv
tb/board_status_tb.sv

//--- Bender.yml
package:
  name: board_status

sources:
  - design/board_status_pkg.sv
  - design/run_status_regs.sv
  - design/seg_scan_ctrl.sv
  - design/board_led_ctrl.sv
  - design/board_status_top.sv
  - target: simulation
    files:
      - tb/tb_clk_gen.sv
      - tb/board_status_tb.sv
